/* filelist.f */
rtl/load_pkg.sv
rtl/free_slot_picker.sv
rtl/miss_tracker.sv
rtl/load_buffer.sv
rtl/result_arbiter.sv
rtl/load_unit_top.sv
verif/load_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the load unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --top-module load_unit_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vload_unit_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* verif/load_unit_tb.sv */
`timescale 1ns/1ps

module load_unit_tb;

    import load_pkg::*;

    logic                        clock;
    logic                        reset;
    logic                        load_valid;
    logic                        load_ready;
    logic [addr_width-1:0]       load_addr;
    load_func_e                  load_func;
    logic [tag_width-1:0]        load_tag;
    logic [bmask_width-1:0]      load_bmask;
    logic [bmask_width-1:0]      resolve_mask;
    logic                        mispredict;
    logic                        mem_req_valid;
    logic [mshr_idx_width-1:0]   mem_req_idx;
    logic [block_addr_width-1:0] mem_req_addr;
    logic                        mem_resp_valid;
    logic [mshr_idx_width-1:0]   mem_resp_idx;
    logic [fill_width-1:0]       mem_resp_data;
    logic                        cdb_valid;
    logic [tag_width-1:0]        cdb_tag;
    logic [xlen-1:0]             cdb_data;

    // Memory image, responder queue and reference model state
    logic [31:0]                 lfsr_state = 32'h5a20_9a92;
    logic [31:0]                 image [64];
    logic [1:0]                  resp_idx [$];
    logic [block_addr_width-1:0] resp_block [$];
    int                          resp_due [$];
    logic                        live [64];
    logic [31:0]                 exp_data [64];
    logic [3:0]                  live_bmask [64];
    logic [5:0]                  next_tag;
    bit                          hold_resp;
    bit                          last_accept;
    bit                          last_ready;
    int                          live_count;
    int                          squashed;
    int                          req_count;
    int                          cyc;
    int                          checks;
    int                          errors;
    int                          test_errors0;
    int                          tests;
    int                          failed_tests;

    load_unit_top load_unit_top_i (.*);

    always #20 clock = ~clock;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic load_func_e func_of(input int k);
        case (k)
            0: return func_lb;
            1: return func_lh;
            2: return func_lw;
            3: return func_lbu;
            default: return func_lhu;
        endcase
    endfunction

    // Shift down by the byte offset, then extend from the top bit of the size
    function automatic logic [31:0] ref_extend(
        input logic [31:0] word,
        input logic [1:0]  off,
        input logic [2:0]  func
    );
        logic [31:0] sh;
        logic        sgn;
        sh = word >> (8 * int'(off));
        sgn = !func[2];
        if (func[1:0] == 2'd0) begin
            return {{24{sh[7] & sgn}}, sh[7:0]};
        end else if (func[1:0] == 2'd1) begin
            return {{16{sh[15] & sgn}}, sh[15:0]};
        end
        return sh;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != test_errors0) begin
            failed_tests++;
        end
        $display("test %s finished with %0d errors", name, errors - test_errors0);
        test_errors0 = errors;
    endtask

    // One clock cycle that starts and ends on a falling edge with inputs already driven
    task automatic run_cycle();
        int          pick;
        logic [4:0]  blk5;
        pick = -1;
        mem_resp_valid = 1'b0;
        if (!hold_resp) begin
            for (int i = 0; i < resp_idx.size(); i++) begin
                if (pick < 0 && resp_due[i] <= cyc) begin
                    pick = i;
                end
            end
        end
        if (pick >= 0) begin
            blk5 = resp_block[pick][4:0];
            mem_resp_valid = 1'b1;
            mem_resp_idx = resp_idx[pick];
            mem_resp_data = {image[{blk5, 1'b1}], image[{blk5, 1'b0}]};
            resp_idx.delete(pick);
            resp_block.delete(pick);
            resp_due.delete(pick);
        end
        #1;
        last_ready = load_ready;
        last_accept = load_valid && load_ready;
        // Squash before the bus check so a squashed tag cannot complete
        for (int t = 0; t < 64; t++) begin
            if (live[t]) begin
                if (mispredict && |(live_bmask[t] & resolve_mask)) begin
                    live[t] = 1'b0;
                    live_count--;
                    squashed++;
                end else begin
                    live_bmask[t] = live_bmask[t] & ~resolve_mask;
                end
            end
        end
        if (cdb_valid) begin
            if (!live[cdb_tag]) begin
                report_error($sformatf("result bus carried tag %0d with no live load", cdb_tag));
            end else begin
                compare_value("cdb_data", cdb_data, exp_data[cdb_tag]);
                live[cdb_tag] = 1'b0;
                live_count--;
            end
        end
        if (mem_req_valid) begin
            for (int i = 0; i < resp_idx.size(); i++) begin
                if (resp_idx[i] == mem_req_idx) begin
                    report_error("memory request reused an index still outstanding");
                end
                if (resp_block[i] == mem_req_addr) begin
                    report_error("second memory request for a block still outstanding");
                end
            end
            if (resp_idx.size() >= mshr_count) begin
                report_error("more than 4 memory requests outstanding");
            end
            resp_idx.push_back(mem_req_idx);
            resp_block.push_back(mem_req_addr);
            resp_due.push_back(cyc + 1 + int'(rand_bits(4)) % 12);
            req_count++;
        end
        if (last_accept) begin
            if (mispredict && |(load_bmask & resolve_mask)) begin
                squashed++;
            end else begin
                live[load_tag] = 1'b1;
                live_count++;
                live_bmask[load_tag] = load_bmask & ~resolve_mask;
                exp_data[load_tag] = ref_extend(image[load_addr[7:2]], load_addr[1:0], load_func);
            end
        end
        cyc++;
        @(negedge clock);
    endtask

    task automatic issue_load(input logic [31:0] addr, input load_func_e func,
                              input logic [3:0] bmask, input int limit, output bit accepted);
        int waited;
        waited = 0;
        accepted = 1'b0;
        while (live[next_tag]) begin
            next_tag = next_tag + 6'd1;
        end
        load_valid = 1'b1;
        load_addr = addr;
        load_func = func;
        load_tag = next_tag;
        load_bmask = bmask;
        while (!accepted && waited < limit) begin
            run_cycle();
            accepted = last_accept;
            // Branch inputs are one-cycle pulses
            resolve_mask = '0;
            mispredict = 1'b0;
            waited++;
        end
        load_valid = 1'b0;
        if (accepted) begin
            next_tag = next_tag + 6'd1;
        end
    endtask

    // Dispatch a load that the DUT has to take within the limit
    task automatic dispatch_load(input logic [31:0] addr, input load_func_e func,
                                 input logic [3:0] bmask, input int limit);
        bit accepted;
        issue_load(addr, func, bmask, limit, accepted);
        if (!accepted) begin
            report_error($sformatf("load to address %h was never accepted", addr));
        end
    endtask

    task automatic drain_loads(input int limit);
        int waited;
        waited = 0;
        while ((live_count > 0 || resp_idx.size() > 0) && waited < limit) begin
            run_cycle();
            waited++;
        end
        if (live_count > 0 || resp_idx.size() > 0) begin
            report_error($sformatf("timeout with %0d loads never finished", live_count));
        end
    endtask

    initial begin
        bit          ok;
        load_func_e  f;
        logic [2:0]  off3;
        int          step;
        int          base;
        clock = 1'b0;
        reset = 1'b1;
        load_valid = 1'b0;
        load_addr = '0;
        load_func = func_lb;
        load_tag = '0;
        load_bmask = '0;
        resolve_mask = '0;
        mispredict = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_idx = '0;
        mem_resp_data = '0;
        next_tag = '0;
        for (int i = 0; i < 64; i++) begin
            image[i] = rand_bits(32);
            live[i] = 1'b0;
        end
        repeat (5) @(negedge clock);
        reset = 1'b0;
        #1;
        compare_value("load_ready", 32'(load_ready), 32'd1);
        compare_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
        compare_value("cdb_valid", 32'(cdb_valid), 32'd0);
        @(negedge clock);
        finish_test("reset_state");

        // Every function at every legal offset within a block
        for (int k = 0; k < 5; k++) begin
            f = func_of(k);
            step = (f[1:0] == 2'd0) ? 1 : ((f[1:0] == 2'd1) ? 2 : 4);
            for (int off = 0; off < 8; off += step) begin
                dispatch_load({24'b0, 5'(16 + k), 3'(off)}, f, 4'b0, 20);
                drain_loads(100);
            end
        end
        finish_test("extension");

        for (int n = 0; n < 300; n++) begin
            f = func_of(int'(rand_bits(3)) % 5);
            off3 = 3'(rand_bits(3));
            if (f[1:0] == 2'd1) begin
                off3[0] = 1'b0;
            end else if (f[1:0] == 2'd2) begin
                off3[1:0] = 2'b00;
            end
            if (rand_bits(3) == 0) begin
                resolve_mask = 4'b0001 << rand_bits(2);
                mispredict = (rand_bits(2) == 0);
            end
            issue_load({24'b0, 1'b0, 4'(rand_bits(4)), off3}, f, 4'(rand_bits(4)), 200, ok);
            if (!ok) begin
                report_error($sformatf("random load %0d was never accepted", n));
            end
            if (rand_bits(2) == 0) begin
                run_cycle();
            end
        end
        drain_loads(600);
        finish_test("random");

        hold_resp = 1'b1;
        base = req_count;
        for (int i = 0; i < 6; i++) begin
            dispatch_load({24'b0, 5'd7, 3'(i)}, func_lbu, 4'b0, 20);
        end
        repeat (2) run_cycle();
        compare_value("mem_req_valid pulses", 32'(req_count - base), 32'd1);
        hold_resp = 1'b0;
        drain_loads(100);
        finish_test("merge");

        hold_resp = 1'b1;
        base = squashed;
        dispatch_load({24'b0, 5'd1, 3'd0}, func_lw, 4'b0001, 20);
        dispatch_load({24'b0, 5'd1, 3'd4}, func_lh, 4'b0001, 20);
        dispatch_load({24'b0, 5'd2, 3'd1}, func_lb, 4'b0010, 20);
        dispatch_load({24'b0, 5'd2, 3'd6}, func_lhu, 4'b0010, 20);
        dispatch_load({24'b0, 5'd3, 3'd3}, func_lbu, 4'b0011, 20);
        dispatch_load({24'b0, 5'd3, 3'd4}, func_lw, 4'b0000, 20);
        // Branch 0 resolves correct, branch 1 mispredicts
        resolve_mask = 4'b0001;
        run_cycle();
        resolve_mask = 4'b0010;
        mispredict = 1'b1;
        run_cycle();
        // A load dispatched under a branch that mispredicts in the same cycle
        resolve_mask = 4'b0100;
        mispredict = 1'b1;
        dispatch_load({24'b0, 5'd4, 3'd0}, func_lw, 4'b0100, 20);
        hold_resp = 1'b0;
        drain_loads(100);
        compare_value("squashed loads", 32'(squashed - base), 32'd4);
        finish_test("squash");

        // Eight loads to one block fill every slot
        hold_resp = 1'b1;
        for (int i = 0; i < 8; i++) begin
            dispatch_load({24'b0, 5'd9, 3'(i)}, func_lb, 4'b0, 20);
        end
        issue_load({24'b0, 5'd9, 3'd2}, func_lh, 4'b0, 4, ok);
        compare_value("load_ready", 32'(last_ready), 32'd0);
        hold_resp = 1'b0;
        issue_load({24'b0, 5'd9, 3'd2}, func_lh, 4'b0, 100, ok);
        compare_value("accepted after release", 32'(ok), 32'd1);
        drain_loads(100);
        // Four distinct blocks take every tracker entry
        hold_resp = 1'b1;
        for (int i = 0; i < 4; i++) begin
            dispatch_load({24'b0, 5'(10 + i), 3'd0}, func_lw, 4'b0, 20);
        end
        issue_load({24'b0, 5'd14, 3'd0}, func_lw, 4'b0, 4, ok);
        compare_value("load_ready", 32'(last_ready), 32'd0);
        hold_resp = 1'b0;
        issue_load({24'b0, 5'd14, 3'd0}, func_lw, 4'b0, 100, ok);
        compare_value("accepted after release", 32'(ok), 32'd1);
        drain_loads(100);
        finish_test("backpressure");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* rtl/load_unit_top.sv */
`timescale 1ns/1ps

module load_unit_top (
    input  logic                                 clock,
    input  logic                                 reset,

    input  logic                                 load_valid,
    output logic                                 load_ready,
    input  logic [load_pkg::addr_width-1:0]      load_addr,
    input  load_pkg::load_func_e                 load_func,
    input  logic [load_pkg::tag_width-1:0]       load_tag,
    input  logic [load_pkg::bmask_width-1:0]     load_bmask,

    input  logic [load_pkg::bmask_width-1:0]     resolve_mask,
    input  logic                                 mispredict,

    output logic                                 mem_req_valid,
    output logic [load_pkg::mshr_idx_width-1:0]  mem_req_idx,
    output logic [load_pkg::block_addr_width-1:0] mem_req_addr,
    input  logic                                 mem_resp_valid,
    input  logic [load_pkg::mshr_idx_width-1:0]  mem_resp_idx,
    input  logic [load_pkg::fill_width-1:0]      mem_resp_data,

    output logic                                 cdb_valid,
    output logic [load_pkg::tag_width-1:0]       cdb_tag,
    output logic [load_pkg::xlen-1:0]            cdb_data
);

    import load_pkg::*;

    logic                                  load_accept;
    logic                                  mshr_ready;
    logic [mshr_idx_width-1:0]             alloc_idx;
    logic                                  fill_valid;
    logic [mshr_idx_width-1:0]             fill_idx;
    logic [fill_width-1:0]                 fill_data;
    logic [load_slots-1:0]                 ready_mask;
    logic [load_slots-1:0]                 grant_mask;
    logic [load_slots-1:0][tag_width-1:0]  slot_tag;
    logic [load_slots-1:0][xlen-1:0]       slot_result;

    miss_tracker miss_tracker_i (
        .clock(clock),
        .reset(reset),
        .load_accept(load_accept),
        .load_addr(load_addr),
        .mshr_ready(mshr_ready),
        .alloc_idx(alloc_idx),
        .mem_req_valid(mem_req_valid),
        .mem_req_idx(mem_req_idx),
        .mem_req_addr(mem_req_addr),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_idx(mem_resp_idx),
        .mem_resp_data(mem_resp_data),
        .fill_valid(fill_valid),
        .fill_idx(fill_idx),
        .fill_data(fill_data)
    );

    load_buffer load_buffer_i (
        .clock(clock),
        .reset(reset),
        .load_valid(load_valid),
        .load_func(load_func),
        .load_addr(load_addr),
        .load_tag(load_tag),
        .load_bmask(load_bmask),
        .load_ready(load_ready),
        .load_accept(load_accept),
        .mshr_ready(mshr_ready),
        .alloc_idx(alloc_idx),
        .fill_valid(fill_valid),
        .fill_idx(fill_idx),
        .fill_data(fill_data),
        .resolve_mask(resolve_mask),
        .mispredict(mispredict),
        .grant_mask(grant_mask),
        .ready_mask(ready_mask),
        .slot_tag(slot_tag),
        .slot_result(slot_result)
    );

    result_arbiter result_arbiter_i (
        .clock(clock),
        .reset(reset),
        .ready_mask(ready_mask),
        .slot_tag(slot_tag),
        .slot_result(slot_result),
        .grant_mask(grant_mask),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_data(cdb_data)
    );

endmodule

/* rtl/result_arbiter.sv */
`timescale 1ns/1ps

module result_arbiter (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [load_pkg::load_slots-1:0]      ready_mask,
    input  logic [load_pkg::load_slots-1:0][load_pkg::tag_width-1:0] slot_tag,
    input  logic [load_pkg::load_slots-1:0][load_pkg::xlen-1:0]      slot_result,
    output logic [load_pkg::load_slots-1:0]      grant_mask,
    output logic                                 cdb_valid,
    output logic [load_pkg::tag_width-1:0]       cdb_tag,
    output logic [load_pkg::xlen-1:0]            cdb_data
);

    import load_pkg::*;

    logic [slot_idx_width-1:0] rr_ptr;
    logic [slot_idx_width-1:0] grant_idx;
    logic [slot_idx_width-1:0] scan_idx;
    logic                      found;

    // Scan upward from the pointer with the index wrapping at its width
    always_comb begin
        grant_mask = '0;
        grant_idx = '0;
        scan_idx = '0;
        found = 1'b0;
        for (int k = 0; k < load_slots; k++) begin
            scan_idx = rr_ptr + slot_idx_width'(k);
            if (ready_mask[scan_idx] && !found) begin
                found = 1'b1;
                grant_mask[scan_idx] = 1'b1;
                grant_idx = scan_idx;
            end
        end
    end

    assign cdb_valid = found;
    assign cdb_tag = slot_tag[grant_idx];
    assign cdb_data = slot_result[grant_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (found) begin
            rr_ptr <= grant_idx + slot_idx_width'(1);
        end
    end

endmodule

/* rtl/load_buffer.sv */
`timescale 1ns/1ps

module load_buffer (
    input  logic                                 clock,
    input  logic                                 reset,

    input  logic                                 load_valid,
    input  load_pkg::load_func_e                 load_func,
    input  logic [load_pkg::addr_width-1:0]      load_addr,
    input  logic [load_pkg::tag_width-1:0]       load_tag,
    input  logic [load_pkg::bmask_width-1:0]     load_bmask,
    output logic                                 load_ready,
    output logic                                 load_accept,

    input  logic                                 mshr_ready,
    input  logic [load_pkg::mshr_idx_width-1:0]  alloc_idx,

    input  logic                                 fill_valid,
    input  logic [load_pkg::mshr_idx_width-1:0]  fill_idx,
    input  logic [load_pkg::fill_width-1:0]      fill_data,

    input  logic [load_pkg::bmask_width-1:0]     resolve_mask,
    input  logic                                 mispredict,

    input  logic [load_pkg::load_slots-1:0]      grant_mask,
    output logic [load_pkg::load_slots-1:0]      ready_mask,
    output logic [load_pkg::load_slots-1:0][load_pkg::tag_width-1:0] slot_tag,
    output logic [load_pkg::load_slots-1:0][load_pkg::xlen-1:0]      slot_result
);

    import load_pkg::*;

    logic [load_slots-1:0]     slot_valid;
    logic [load_slots-1:0]     slot_waiting;
    logic [2:0]                slot_addr    [load_slots];
    load_func_e                slot_func    [load_slots];
    logic [tag_width-1:0]      slot_tags    [load_slots];
    logic [bmask_width-1:0]    slot_bmask   [load_slots];
    logic [mshr_idx_width-1:0] slot_midx    [load_slots];
    logic [xlen-1:0]           slot_word    [load_slots];

    logic [load_slots-1:0]     free_pick;
    logic                      any_free;
    logic [load_slots-1:0]     new_slot;
    logic [load_slots-1:0]     squash;
    logic [load_slots-1:0]     fill_hit;
    logic                      new_dropped;

    free_slot_picker #(
        .width(load_slots)
    ) slot_picker (
        .free_mask(~slot_valid),
        .pick(free_pick),
        .any_free(any_free)
    );

    // Slots freed by a grant this cycle are not reused until the next one
    assign load_ready = any_free && mshr_ready;
    assign load_accept = load_valid && load_ready;
    assign new_slot = load_accept ? free_pick : '0;

    // Incoming load that depends on a branch mispredicted this same cycle
    assign new_dropped = mispredict && |(load_bmask & resolve_mask);

    always_comb begin
        for (int i = 0; i < load_slots; i++) begin
            squash[i] = slot_valid[i] && mispredict && |(slot_bmask[i] & resolve_mask);
            fill_hit[i] = fill_valid && slot_valid[i] && slot_waiting[i] &&
                          (slot_midx[i] == fill_idx);
        end
    end

    // Squashed entries drop out of the request here, so the bus never sees them
    always_comb begin
        for (int i = 0; i < load_slots; i++) begin
            ready_mask[i] = slot_valid[i] && !slot_waiting[i] && !squash[i];
            slot_tag[i] = slot_tags[i];
            slot_result[i] = extend_load(slot_word[i], slot_addr[i][1:0], slot_func[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            slot_valid <= '0;
            slot_waiting <= '0;
        end else begin
            for (int i = 0; i < load_slots; i++) begin
                if (new_slot[i]) begin
                    slot_valid[i] <= !new_dropped;
                    slot_waiting[i] <= 1'b1;
                end else begin
                    if (squash[i] || grant_mask[i]) begin
                        slot_valid[i] <= 1'b0;
                    end
                    if (fill_hit[i]) begin
                        slot_waiting[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < load_slots; i++) begin
            if (new_slot[i]) begin
                slot_addr[i] <= load_addr[2:0];
                slot_func[i] <= load_func;
                slot_tags[i] <= load_tag;
                slot_bmask[i] <= load_bmask & ~resolve_mask;
                slot_midx[i] <= alloc_idx;
            end else begin
                // Resolved branches no longer guard this load
                slot_bmask[i] <= slot_bmask[i] & ~resolve_mask;
                if (fill_hit[i]) begin
                    // Address bit 2 picks the word within the block
                    slot_word[i] <= fill_data[int'(slot_addr[i][2]) * xlen +: xlen];
                end
            end
        end
    end

endmodule

/* rtl/miss_tracker.sv */
`timescale 1ns/1ps

module miss_tracker (
    input  logic                                 clock,
    input  logic                                 reset,

    input  logic                                 load_accept,
    input  logic [load_pkg::addr_width-1:0]      load_addr,
    output logic                                 mshr_ready,
    output logic [load_pkg::mshr_idx_width-1:0]  alloc_idx,

    output logic                                 mem_req_valid,
    output logic [load_pkg::mshr_idx_width-1:0]  mem_req_idx,
    output logic [load_pkg::block_addr_width-1:0] mem_req_addr,

    input  logic                                 mem_resp_valid,
    input  logic [load_pkg::mshr_idx_width-1:0]  mem_resp_idx,
    input  logic [load_pkg::fill_width-1:0]      mem_resp_data,

    output logic                                 fill_valid,
    output logic [load_pkg::mshr_idx_width-1:0]  fill_idx,
    output logic [load_pkg::fill_width-1:0]      fill_data
);

    import load_pkg::*;

    logic                        entry_valid [mshr_count];
    logic [block_addr_width-1:0] entry_block [mshr_count];

    logic [block_addr_width-1:0] in_block;
    logic [mshr_count-1:0]       hit_mask;
    logic [mshr_count-1:0]       free_mask;
    logic [mshr_count-1:0]       free_pick;
    logic                        any_free;
    logic                        hit;
    logic                        new_alloc;

    assign in_block = load_addr[addr_width-1:block_offset_width];

    // An entry being filled this cycle is gone by the next edge, so no merge onto it
    always_comb begin
        for (int i = 0; i < mshr_count; i++) begin
            hit_mask[i] = entry_valid[i] && (entry_block[i] == in_block) &&
                          !(mem_resp_valid && (mem_resp_idx == mshr_idx_width'(i)));
            free_mask[i] = !entry_valid[i];
        end
    end

    free_slot_picker #(
        .width(mshr_count)
    ) entry_picker (
        .free_mask(free_mask),
        .pick(free_pick),
        .any_free(any_free)
    );

    assign hit = |hit_mask;
    assign mshr_ready = hit || any_free;
    assign new_alloc = load_accept && !hit;

    // Merged entry if any, else the lowest free one
    always_comb begin
        alloc_idx = '0;
        for (int i = 0; i < mshr_count; i++) begin
            if (hit ? hit_mask[i] : free_pick[i]) begin
                alloc_idx = mshr_idx_width'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mshr_count; i++) begin
                entry_valid[i] <= 1'b0;
            end
            mem_req_valid <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            if (mem_resp_valid) begin
                entry_valid[mem_resp_idx] <= 1'b0;
            end
            // Allocation only targets free entries, never the one being filled
            if (new_alloc) begin
                entry_valid[alloc_idx] <= 1'b1;
            end
            mem_req_valid <= new_alloc;
            fill_valid <= mem_resp_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (new_alloc) begin
            entry_block[alloc_idx] <= in_block;
            mem_req_idx <= alloc_idx;
            mem_req_addr <= in_block;
        end
        fill_idx <= mem_resp_idx;
        fill_data <= mem_resp_data;
    end

endmodule

/* rtl/free_slot_picker.sv */
`timescale 1ns/1ps

module free_slot_picker #(
    parameter int width = load_pkg::load_slots
) (
    input  logic [width-1:0] free_mask,
    output logic [width-1:0] pick,
    output logic             any_free
);

    logic found;

    // Lowest set bit wins
    always_comb begin
        pick = '0;
        found = 1'b0;
        for (int i = 0; i < width; i++) begin
            if (free_mask[i] && !found) begin
                pick[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

    assign any_free = |free_mask;

endmodule

/* rtl/load_pkg.sv */
package load_pkg;

    // Buffer and tracker sizes
    localparam int load_slots = 8;
    localparam int slot_idx_width = 3;
    localparam int mshr_count = 4;
    localparam int mshr_idx_width = 2;

    // Tag and branch mask widths
    localparam int tag_width = 6;
    localparam int bmask_width = 4;

    // Data and address geometry for an 8-byte fill block
    localparam int xlen = 32;
    localparam int addr_width = 32;
    localparam int block_words = 2;
    localparam int fill_width = block_words * xlen;
    localparam int block_offset_width = 3;
    localparam int block_addr_width = addr_width - block_offset_width;

    typedef enum logic [1:0] {
        byte_size = 2'b00,
        half_size = 2'b01,
        word_size = 2'b10
    } mem_size_e;

    // Bit 2 is the unsigned flag, bits 1:0 the size, as in funct3
    typedef enum logic [2:0] {
        func_lb  = 3'b000,
        func_lh  = 3'b001,
        func_lw  = 3'b010,
        func_lbu = 3'b100,
        func_lhu = 3'b101
    } load_func_e;

    function automatic logic [xlen-1:0] extend_load(
        input logic [xlen-1:0] word,
        input logic [1:0]      offset,
        input load_func_e      func
    );
        logic [xlen-1:0] shifted;
        mem_size_e       size;
        shifted = word >> {offset, 3'b000};
        size = mem_size_e'(func[1:0]);
        case (size)
            byte_size: begin
                extend_load = func[2] ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
            end
            half_size: begin
                extend_load = func[2] ? {16'b0, shifted[15:0]}
                                      : {{16{shifted[15]}}, shifted[15:0]};
            end
            default: begin
                extend_load = shifted;
            end
        endcase
    endfunction

endpackage
